// ==== hdl/acc_isa_pkg.sv ====
`default_nettype none

package acc_isa_pkg;

	localparam int OPCODE_W = 8;
	localparam int INST_W = 24;
	localparam int DATA_W = 16;
	localparam int ADDR_W = 16;

	// opcode in the low byte, operand in bits 23:8
	typedef logic [INST_W-1:0] inst_word_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP         = 8'h00,
		OP_LD_XL_IMMD  = 8'h01,
		OP_LDW_Y_IMMD  = 8'h02,
		OP_LD_XL_DIR   = 8'h03,
		OP_LD_DIR_XL   = 8'h04,
		OP_LDW_Y_DIR   = 8'h05,
		OP_LDW_DIR_Y   = 8'h06,
		OP_ADD_XL_IMMD = 8'h10,
		OP_SUB_XL_IMMD = 8'h11,
		OP_AND_XL_IMMD = 8'h12,
		OP_OR_XL_IMMD  = 8'h13,
		OP_XOR_XL_IMMD = 8'h14,
		OP_CP_XL_IMMD  = 8'h15,
		OP_ADD_XL_DIR  = 8'h18,
		OP_ADDW_Y_IMMD = 8'h20,
		OP_SUBW_Y_IMMD = 8'h21,
		OP_LDW_Z_Y     = 8'h28,
		OP_LDW_Y_Z     = 8'h29,
		OP_JP_IMMD     = 8'h30,
		OP_JR_D        = 8'h38,
		OP_JRZ_D       = 8'h39,
		OP_JRNZ_D      = 8'h3a,
		OP_JRC_D       = 8'h3b,
		OP_JRNC_D      = 8'h3c,
		OP_TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_t;

	// instruction size in bytes
	function automatic logic [1:0] inst_length(opcode_t op);
		case (op)
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
			OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_CP_XL_IMMD,
			OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
				return 2'd2;
			OP_LDW_Y_IMMD, OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_DIR, OP_LDW_DIR_Y,
			OP_ADD_XL_DIR, OP_ADDW_Y_IMMD, OP_SUBW_Y_IMMD, OP_JP_IMMD:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hdl/acc_alu_pkg.sv ====
`default_nettype none

package acc_alu_pkg;

	typedef enum logic [2:0] {
		ALU_PASS = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_OR   = 3'd4,
		ALU_XOR  = 3'd5,
		ALU_ADDW = 3'd6,
		ALU_SUBW = 3'd7
	} alu_op_t;

	typedef logic [3:0] flag_vec_t;

	// bit positions inside flag_vec_t
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_O = 3;

endpackage

`default_nettype wire

// ==== hdl/issue_stage.sv ====
`default_nettype none

module issue_stage #(
	parameter logic [acc_isa_pkg::ADDR_W-1:0] RESET_PC = 16'h4000
) (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire acc_isa_pkg::inst_word_t           iread_data,
	input  wire acc_alu_pkg::flag_vec_t            next_flags,
	output logic       [acc_isa_pkg::ADDR_W-1:0]   iread_addr,
	output logic       [acc_isa_pkg::ADDR_W-1:0]   dread_addr,
	output acc_isa_pkg::inst_word_t                inst
);

	acc_isa_pkg::opcode_t op;
	logic [acc_isa_pkg::ADDR_W-1:0] pc;
	logic [acc_isa_pkg::ADDR_W-1:0] next_pc;
	logic [acc_isa_pkg::ADDR_W-1:0] step;
	logic [acc_isa_pkg::ADDR_W-1:0] disp;
	logic [acc_isa_pkg::ADDR_W-1:0] operand;
	logic taken;

	assign op = acc_isa_pkg::opcode_t'(iread_data[7:0]);
	assign operand = iread_data[23:8];
	assign disp = {{(acc_isa_pkg::ADDR_W-8){iread_data[15]}}, iread_data[15:8]};

	// flags are those left by the instruction now in execute
	always_comb
	begin
		case (op)
			acc_isa_pkg::OP_JR_D:   taken = 1'b1;
			acc_isa_pkg::OP_JRZ_D:  taken = next_flags[acc_alu_pkg::FLAG_Z];
			acc_isa_pkg::OP_JRNZ_D: taken = !next_flags[acc_alu_pkg::FLAG_Z];
			acc_isa_pkg::OP_JRC_D:  taken = next_flags[acc_alu_pkg::FLAG_C];
			acc_isa_pkg::OP_JRNC_D: taken = !next_flags[acc_alu_pkg::FLAG_C];
			default:                taken = 1'b0;
		endcase
	end

	always_comb
	begin
		step = '0;
		step[1:0] = acc_isa_pkg::inst_length(op);
		if (reset)
			next_pc = RESET_PC;
		else if (op == acc_isa_pkg::OP_JP_IMMD)
			next_pc = operand;
		else if (taken)
			next_pc = pc + disp;
		else
			next_pc = pc + step;
	end

	assign iread_addr = next_pc;

	// data read is issued one cycle ahead of execute
	always_comb
	begin
		case (op)
			acc_isa_pkg::OP_LD_XL_DIR,
			acc_isa_pkg::OP_LDW_Y_DIR,
			acc_isa_pkg::OP_ADD_XL_DIR:
				dread_addr = operand;
			default:
				dread_addr = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
			inst <= {16'h0000, acc_isa_pkg::OP_NOP};
		end
		else
		begin
			pc <= next_pc;
			inst <= iread_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/exec_decode.sv ====
`default_nettype none

module exec_decode (
	input  wire acc_isa_pkg::inst_word_t          inst,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]   x,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]   y,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]   z,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]   dread_data,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]   alu_result,
	output acc_alu_pkg::alu_op_t                  alu_op,
	output logic [acc_isa_pkg::DATA_W-1:0]        alu_a,
	output logic [acc_isa_pkg::DATA_W-1:0]        alu_b,
	output acc_isa_pkg::reg_sel_t                 write_sel,
	output logic [1:0]                            write_en,
	output logic [acc_isa_pkg::DATA_W-1:0]        write_data,
	output logic [acc_isa_pkg::ADDR_W-1:0]        dwrite_addr,
	output logic [acc_isa_pkg::DATA_W-1:0]        dwrite_data,
	output logic [1:0]                            dwrite_en,
	output acc_alu_pkg::flag_vec_t                flag_upd,
	output logic                                  trap
);

	acc_isa_pkg::opcode_t op;
	logic [acc_isa_pkg::DATA_W-1:0] imm8;
	logic [acc_isa_pkg::DATA_W-1:0] imm16;

	assign op = acc_isa_pkg::opcode_t'(inst[7:0]);
	assign imm8 = {8'h00, inst[15:8]};
	assign imm16 = inst[23:8];

	// every register write comes out of the ALU
	assign write_data = alu_result;
	assign dwrite_addr = inst[23:8];
	assign trap = (op == acc_isa_pkg::OP_TRAP);

	always_comb
	begin
		alu_op = acc_alu_pkg::ALU_PASS;
		alu_a = x;
		alu_b = imm8;
		write_sel = acc_isa_pkg::REG_X;
		write_en = 2'b00;
		dwrite_data = x;
		dwrite_en = 2'b00;
		flag_upd = '0;

		case (op)
			acc_isa_pkg::OP_LD_XL_IMMD:
				write_en = 2'b01;
			acc_isa_pkg::OP_LD_XL_DIR:
			begin
				alu_b = dread_data;
				write_en = 2'b01;
			end
			acc_isa_pkg::OP_LDW_Y_IMMD:
			begin
				alu_b = imm16;
				write_sel = acc_isa_pkg::REG_Y;
				write_en = 2'b11;
			end
			acc_isa_pkg::OP_LDW_Y_DIR:
			begin
				alu_b = dread_data;
				write_sel = acc_isa_pkg::REG_Y;
				write_en = 2'b11;
			end
			acc_isa_pkg::OP_LDW_Z_Y:
			begin
				alu_b = y;
				write_sel = acc_isa_pkg::REG_Z;
				write_en = 2'b11;
			end
			acc_isa_pkg::OP_LDW_Y_Z:
			begin
				alu_b = z;
				write_sel = acc_isa_pkg::REG_Y;
				write_en = 2'b11;
			end
			// xl goes out on lane 0 only
			acc_isa_pkg::OP_LD_DIR_XL:
				dwrite_en = 2'b01;
			acc_isa_pkg::OP_LDW_DIR_Y:
			begin
				dwrite_data = y;
				dwrite_en = 2'b11;
			end
			acc_isa_pkg::OP_ADD_XL_IMMD,
			acc_isa_pkg::OP_SUB_XL_IMMD:
			begin
				alu_op = (op == acc_isa_pkg::OP_ADD_XL_IMMD) ?
					acc_alu_pkg::ALU_ADD : acc_alu_pkg::ALU_SUB;
				write_en = 2'b01;
				flag_upd = '1;
			end
			acc_isa_pkg::OP_ADD_XL_DIR:
			begin
				alu_op = acc_alu_pkg::ALU_ADD;
				alu_b = dread_data;
				write_en = 2'b01;
				flag_upd = '1;
			end
			// compare is a sub without the write
			acc_isa_pkg::OP_CP_XL_IMMD:
			begin
				alu_op = acc_alu_pkg::ALU_SUB;
				flag_upd = '1;
			end
			acc_isa_pkg::OP_AND_XL_IMMD,
			acc_isa_pkg::OP_OR_XL_IMMD,
			acc_isa_pkg::OP_XOR_XL_IMMD:
			begin
				if (op == acc_isa_pkg::OP_AND_XL_IMMD)
					alu_op = acc_alu_pkg::ALU_AND;
				else if (op == acc_isa_pkg::OP_OR_XL_IMMD)
					alu_op = acc_alu_pkg::ALU_OR;
				else
					alu_op = acc_alu_pkg::ALU_XOR;
				write_en = 2'b01;
				flag_upd[acc_alu_pkg::FLAG_Z] = 1'b1;
				flag_upd[acc_alu_pkg::FLAG_N] = 1'b1;
			end
			acc_isa_pkg::OP_ADDW_Y_IMMD,
			acc_isa_pkg::OP_SUBW_Y_IMMD:
			begin
				alu_op = (op == acc_isa_pkg::OP_ADDW_Y_IMMD) ?
					acc_alu_pkg::ALU_ADDW : acc_alu_pkg::ALU_SUBW;
				alu_a = y;
				alu_b = imm16;
				write_sel = acc_isa_pkg::REG_Y;
				write_en = 2'b11;
				flag_upd = '1;
			end
			default:
				;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/acc_alu.sv ====
`default_nettype none

module acc_alu (
	input  wire acc_alu_pkg::alu_op_t              alu_op,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]    alu_a,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]    alu_b,
	output logic [acc_isa_pkg::DATA_W-1:0]         alu_result,
	output acc_alu_pkg::flag_vec_t                 alu_flags
);

	logic [8:0] sum8;
	logic [8:0] dif8;
	logic [acc_isa_pkg::DATA_W:0] sum16;
	logic [acc_isa_pkg::DATA_W:0] dif16;
	logic carry;
	logic ovf;
	logic wide;

	assign sum8 = {1'b0, alu_a[7:0]} + {1'b0, alu_b[7:0]};
	assign dif8 = {1'b0, alu_a[7:0]} - {1'b0, alu_b[7:0]};
	assign sum16 = {1'b0, alu_a} + {1'b0, alu_b};
	assign dif16 = {1'b0, alu_a} - {1'b0, alu_b};

	always_comb
	begin
		alu_result = alu_b;
		carry = 1'b0;
		ovf = 1'b0;
		wide = 1'b0;
		case (alu_op)
			acc_alu_pkg::ALU_ADD:
			begin
				alu_result = {8'h00, sum8[7:0]};
				carry = sum8[8];
				ovf = (alu_a[7] == alu_b[7]) && (sum8[7] != alu_a[7]);
			end
			// carry holds the borrow
			acc_alu_pkg::ALU_SUB:
			begin
				alu_result = {8'h00, dif8[7:0]};
				carry = dif8[8];
				ovf = (alu_a[7] != alu_b[7]) && (dif8[7] != alu_a[7]);
			end
			acc_alu_pkg::ALU_AND:
				alu_result = {8'h00, alu_a[7:0] & alu_b[7:0]};
			acc_alu_pkg::ALU_OR:
				alu_result = {8'h00, alu_a[7:0] | alu_b[7:0]};
			acc_alu_pkg::ALU_XOR:
				alu_result = {8'h00, alu_a[7:0] ^ alu_b[7:0]};
			acc_alu_pkg::ALU_ADDW:
			begin
				alu_result = sum16[15:0];
				carry = sum16[16];
				ovf = (alu_a[15] == alu_b[15]) && (sum16[15] != alu_a[15]);
				wide = 1'b1;
			end
			acc_alu_pkg::ALU_SUBW:
			begin
				alu_result = dif16[15:0];
				carry = dif16[16];
				ovf = (alu_a[15] != alu_b[15]) && (dif16[15] != alu_a[15]);
				wide = 1'b1;
			end
			default:
				wide = 1'b1;
		endcase
	end

	// z and n follow the width of the operation
	always_comb
	begin
		alu_flags[acc_alu_pkg::FLAG_C] = carry;
		alu_flags[acc_alu_pkg::FLAG_O] = ovf;
		alu_flags[acc_alu_pkg::FLAG_Z] = wide ? (alu_result == '0) : (alu_result[7:0] == 8'h00);
		alu_flags[acc_alu_pkg::FLAG_N] = wide ? alu_result[15] : alu_result[7];
	end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

module regfile (
	input  wire logic                              clk,
	input  wire acc_isa_pkg::reg_sel_t             write_sel,
	input  wire logic [1:0]                        write_en,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]    write_data,
	output logic [acc_isa_pkg::DATA_W-1:0]         x,
	output logic [acc_isa_pkg::DATA_W-1:0]         y,
	output logic [acc_isa_pkg::DATA_W-1:0]         z
);

	logic [acc_isa_pkg::DATA_W-1:0] regs [3];

	// x, y, z in select order
	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (write_sel == 2'(i))
			begin
				if (write_en[0])
					regs[i][7:0] <= write_data[7:0];
				if (write_en[1])
					regs[i][15:8] <= write_data[15:8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/flag_unit.sv ====
`default_nettype none

module flag_unit (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire acc_alu_pkg::flag_vec_t    alu_flags,
	input  wire acc_alu_pkg::flag_vec_t    flag_upd,
	output acc_alu_pkg::flag_vec_t         flags,
	output acc_alu_pkg::flag_vec_t         next_flags
);

	// per flag merge of new and old values
	assign next_flags = (flag_upd & alu_flags) | (~flag_upd & flags);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

`default_nettype wire

// ==== hdl/acc_cpu.sv ====
`default_nettype none

module acc_cpu #(
	parameter logic [acc_isa_pkg::ADDR_W-1:0] RESET_PC = 16'h4000
) (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire acc_isa_pkg::inst_word_t           iread_data,
	input  wire logic [acc_isa_pkg::DATA_W-1:0]    dread_data,
	output logic [acc_isa_pkg::ADDR_W-1:0]         iread_addr,
	output logic [acc_isa_pkg::ADDR_W-1:0]         dread_addr,
	output logic [acc_isa_pkg::ADDR_W-1:0]         dwrite_addr,
	output logic [acc_isa_pkg::DATA_W-1:0]         dwrite_data,
	output logic [1:0]                             dwrite_en,
	output logic                                   trap
);

	acc_isa_pkg::inst_word_t inst;
	acc_alu_pkg::flag_vec_t next_flags;
	acc_alu_pkg::flag_vec_t alu_flags;
	acc_alu_pkg::flag_vec_t flag_upd;
	acc_alu_pkg::alu_op_t alu_op;
	logic [acc_isa_pkg::DATA_W-1:0] alu_a;
	logic [acc_isa_pkg::DATA_W-1:0] alu_b;
	logic [acc_isa_pkg::DATA_W-1:0] alu_result;
	acc_isa_pkg::reg_sel_t write_sel;
	logic [1:0] write_en;
	logic [acc_isa_pkg::DATA_W-1:0] write_data;
	logic [acc_isa_pkg::DATA_W-1:0] x;
	logic [acc_isa_pkg::DATA_W-1:0] y;
	logic [acc_isa_pkg::DATA_W-1:0] z;

	issue_stage #(
		.RESET_PC(RESET_PC)
	) u_issue (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst)
	);

	exec_decode u_decode (
		.inst(inst),
		.x(x),
		.y(y),
		.z(z),
		.dread_data(dread_data),
		.alu_result(alu_result),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.write_sel(write_sel),
		.write_en(write_en),
		.write_data(write_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.flag_upd(flag_upd),
		.trap(trap)
	);

	acc_alu u_alu (
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_result(alu_result),
		.alu_flags(alu_flags)
	);

	regfile u_regs (
		.clk(clk),
		.write_sel(write_sel),
		.write_en(write_en),
		.write_data(write_data),
		.x(x),
		.y(y),
		.z(z)
	);

	// only the merged flags leave the unit
	flag_unit u_flags (
		.clk(clk),
		.reset(reset),
		.alu_flags(alu_flags),
		.flag_upd(flag_upd),
		.flags(),
		.next_flags(next_flags)
	);

endmodule

`default_nettype wire

// ==== tb/tb_memories.sv ====
`default_nettype none

// synchronous instruction ROM, one 24-bit word from any byte address
module prog_rom (
	input  wire logic        clk,
	input  wire logic [15:0] addr,
	output logic      [23:0] data
);

	logic [7:0] mem [0:65535];

	always_ff @(posedge clk)
	begin
		data <= {mem[addr + 16'd2], mem[addr + 16'd1], mem[addr]};
	end

endmodule

// byte-addressed data RAM, little-endian, write-first
module data_ram (
	input  wire logic        clk,
	input  wire logic [15:0] raddr,
	input  wire logic [15:0] waddr,
	input  wire logic [15:0] wdata,
	input  wire logic [1:0]  wen,
	output logic      [15:0] rdata
);

	logic [7:0] mem [0:65535];

	// byte as seen after this edge's write
	function automatic logic [7:0] byte_after_write(logic [15:0] a);
		if (wen[0] && a == waddr)
			return wdata[7:0];
		if (wen[1] && a == waddr + 16'd1)
			return wdata[15:8];
		return mem[a];
	endfunction

	initial
	begin
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
	end

	always_ff @(posedge clk)
	begin
		rdata <= {byte_after_write(raddr + 16'd1), byte_after_write(raddr)};
		if (wen[0])
			mem[waddr] <= wdata[7:0];
		if (wen[1])
			mem[waddr + 16'd1] <= wdata[15:8];
	end

endmodule

`default_nettype wire

// ==== tb/tb_acc_cpu.sv ====
`default_nettype none

module tb_acc_cpu;

	localparam logic [15:0] RESET_PC = 16'h4000;

	logic clk;
	logic reset;
	acc_isa_pkg::inst_word_t iread_data;
	logic [15:0] dread_data;
	logic [15:0] iread_addr;
	logic [15:0] dread_addr;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	integer seed = 32'hc9da;
	integer errors = 0;
	integer n_inst = 0;
	integer cycles = 0;
	integer limit = 1000;
	integer reset_edges = 0;
	logic [15:0] asm_pc;

	// reference model state
	logic [7:0] ref_xl;
	logic [15:0] ref_y;
	logic [15:0] ref_z;
	logic ref_c;
	logic ref_zf;

	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic [1:0] exp_en [$];
	logic [15:0] exp_raddr [$];

	acc_isa_pkg::opcode_t ops8 [6];

	acc_cpu #(
		.RESET_PC(RESET_PC)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.dread_data(dread_data),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	prog_rom u_rom (
		.clk(clk),
		.addr(iread_addr),
		.data(iread_data)
	);

	data_ram u_ram (
		.clk(clk),
		.raddr(dread_addr),
		.waddr(dwrite_addr),
		.wdata(dwrite_data),
		.wen(dwrite_en),
		.rdata(dread_data)
	);

	always #10 clk = ~clk;

	task automatic put_byte(logic [7:0] b);
		u_rom.mem[asm_pc] = b;
		asm_pc = asm_pc + 16'd1;
	endtask

	task automatic emit_op(acc_isa_pkg::opcode_t op);
		put_byte(8'(op));
		n_inst++;
	endtask

	task automatic emit_imm8(acc_isa_pkg::opcode_t op, logic [7:0] b);
		emit_op(op);
		put_byte(b);
	endtask

	task automatic emit_imm16(acc_isa_pkg::opcode_t op, logic [15:0] w);
		emit_op(op);
		put_byte(w[7:0]);
		put_byte(w[15:8]);
	endtask

	task automatic expect_write(logic [15:0] a, logic [15:0] d, logic [1:0] en);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_en.push_back(en);
	endtask

	// direct load, with the read address it must issue
	task automatic load_direct(acc_isa_pkg::opcode_t op, logic [15:0] a);
		emit_imm16(op, a);
		exp_raddr.push_back(a);
	endtask

	function automatic logic is_direct_load(logic [7:0] opc);
		return opc == acc_isa_pkg::OP_LD_XL_DIR || opc == acc_isa_pkg::OP_LDW_Y_DIR ||
			opc == acc_isa_pkg::OP_ADD_XL_DIR;
	endfunction

	// store xl and record the lane 0 write
	task automatic store_xl(logic [15:0] a);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, a);
		expect_write(a, {8'h00, ref_xl}, 2'b01);
	endtask

	task automatic store_y(logic [15:0] a);
		emit_imm16(acc_isa_pkg::OP_LDW_DIR_Y, a);
		expect_write(a, ref_y, 2'b11);
	endtask

	// 8-bit result and c/z flags from the instruction set rules
	task automatic model_op8(acc_isa_pkg::opcode_t op, logic [7:0] b);
		logic [8:0] wide;
		logic [7:0] r;
		r = ref_xl;
		case (op)
			acc_isa_pkg::OP_ADD_XL_IMMD, acc_isa_pkg::OP_ADD_XL_DIR:
			begin
				wide = {1'b0, ref_xl} + {1'b0, b};
				r = wide[7:0];
				ref_c = wide[8];
			end
			acc_isa_pkg::OP_SUB_XL_IMMD, acc_isa_pkg::OP_CP_XL_IMMD:
			begin
				r = ref_xl - b;
				ref_c = (ref_xl < b);
			end
			acc_isa_pkg::OP_AND_XL_IMMD:
				r = ref_xl & b;
			acc_isa_pkg::OP_OR_XL_IMMD:
				r = ref_xl | b;
			acc_isa_pkg::OP_XOR_XL_IMMD:
				r = ref_xl ^ b;
			default:
				;
		endcase
		ref_zf = (r == 8'h00);
		if (op != acc_isa_pkg::OP_CP_XL_IMMD)
			ref_xl = r;
	endtask

	// op, then markers that appear only when z or c is set
	task automatic op8_case(acc_isa_pkg::opcode_t op, logic [7:0] a, logic [7:0] b,
		logic [15:0] base);
		emit_imm8(acc_isa_pkg::OP_LD_XL_IMMD, a);
		ref_xl = a;
		emit_imm8(op, b);
		model_op8(op, b);
		emit_imm8(acc_isa_pkg::OP_JRNZ_D, 8'd5);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, base);
		if (ref_zf)
			expect_write(base, {8'h00, ref_xl}, 2'b01);
		emit_imm8(acc_isa_pkg::OP_JRNC_D, 8'd5);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, base + 16'd1);
		if (ref_c)
			expect_write(base + 16'd1, {8'h00, ref_xl}, 2'b01);
		store_xl(base + 16'd2);
	endtask

	task automatic build_program();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [15:0] w;
		asm_pc = RESET_PC;
		ops8[0] = acc_isa_pkg::OP_ADD_XL_IMMD;
		ops8[1] = acc_isa_pkg::OP_SUB_XL_IMMD;
		ops8[2] = acc_isa_pkg::OP_AND_XL_IMMD;
		ops8[3] = acc_isa_pkg::OP_OR_XL_IMMD;
		ops8[4] = acc_isa_pkg::OP_XOR_XL_IMMD;
		ops8[5] = acc_isa_pkg::OP_CP_XL_IMMD;
		ref_c = 1'b0;
		ref_zf = 1'b0;

		// loads and stores, then a load right behind its store
		r1 = $random(seed);
		r2 = $random(seed);
		emit_imm8(acc_isa_pkg::OP_LD_XL_IMMD, r1[7:0]);
		ref_xl = r1[7:0];
		store_xl(16'h0100);
		emit_imm16(acc_isa_pkg::OP_LDW_Y_IMMD, r2[15:0]);
		ref_y = r2[15:0];
		store_y(16'h0102);
		emit_imm16(acc_isa_pkg::OP_LDW_Y_IMMD, r2[31:16]);
		ref_y = r2[31:16];
		store_y(16'h0104);
		load_direct(acc_isa_pkg::OP_LD_XL_DIR, 16'h0104);
		ref_xl = ref_y[7:0];
		store_xl(16'h0106);
		load_direct(acc_isa_pkg::OP_ADD_XL_DIR, 16'h0100);
		model_op8(acc_isa_pkg::OP_ADD_XL_DIR, r1[7:0]);
		store_xl(16'h0108);
		load_direct(acc_isa_pkg::OP_LDW_Y_DIR, 16'h0102);
		ref_y = r2[15:0];
		store_y(16'h010a);

		// second round uses equal operands to force z
		for (int round = 0; round < 2; round++)
		begin
			for (int i = 0; i < 6; i++)
			begin
				r1 = $random(seed);
				op8_case(ops8[i], r1[7:0], (round == 1) ? r1[7:0] : r1[15:8],
					16'h0200 + 16'(round * 32 + i * 4));
			end
		end

		// 16-bit arithmetic and the z copy
		r1 = $random(seed);
		r2 = $random(seed);
		emit_imm16(acc_isa_pkg::OP_LDW_Y_IMMD, r1[15:0]);
		ref_y = r1[15:0];
		emit_imm16(acc_isa_pkg::OP_ADDW_Y_IMMD, r1[31:16]);
		ref_y = ref_y + r1[31:16];
		store_y(16'h0280);
		emit_imm16(acc_isa_pkg::OP_SUBW_Y_IMMD, r2[15:0]);
		ref_y = ref_y - r2[15:0];
		store_y(16'h0282);
		emit_op(acc_isa_pkg::OP_LDW_Z_Y);
		ref_z = ref_y;
		emit_imm16(acc_isa_pkg::OP_LDW_Y_IMMD, r2[31:16]);
		ref_y = r2[31:16];
		store_y(16'h0284);
		emit_op(acc_isa_pkg::OP_LDW_Y_Z);
		ref_y = ref_z;
		store_y(16'h0286);

		// control flow, skipped stores land at 0x02f0
		w = asm_pc + 16'd6;
		emit_imm16(acc_isa_pkg::OP_JP_IMMD, w);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, 16'h02f0);
		emit_imm8(acc_isa_pkg::OP_JR_D, 8'd5);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, 16'h02f1);
		emit_imm8(acc_isa_pkg::OP_LD_XL_IMMD, 8'h05);
		ref_xl = 8'h05;
		emit_imm8(acc_isa_pkg::OP_CP_XL_IMMD, 8'h05);
		model_op8(acc_isa_pkg::OP_CP_XL_IMMD, 8'h05);
		emit_imm8(acc_isa_pkg::OP_JRZ_D, 8'd5);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, 16'h02f2);
		emit_imm8(acc_isa_pkg::OP_JRC_D, 8'd5);
		store_xl(16'h02a0);
		emit_imm8(acc_isa_pkg::OP_CP_XL_IMMD, 8'h09);
		model_op8(acc_isa_pkg::OP_CP_XL_IMMD, 8'h09);
		emit_imm8(acc_isa_pkg::OP_JRC_D, 8'd5);
		emit_imm16(acc_isa_pkg::OP_LD_DIR_XL, 16'h02f3);
		emit_imm8(acc_isa_pkg::OP_JRZ_D, 8'd5);
		store_xl(16'h02a1);

		store_xl(16'h0300);
		emit_op(acc_isa_pkg::OP_TRAP);
	endtask

	// reset values
	always @(posedge clk)
	begin
		if (reset)
		begin
			assert (iread_addr == RESET_PC)
			else
			begin
				$display("ERR iread_addr got %h expected %h", iread_addr, RESET_PC);
				errors++;
			end
			// the first edge loads the NOP into execute
			if (reset_edges > 0)
			begin
				assert (dwrite_en == 2'b00 && !trap)
				else
				begin
					$display("ERR dwrite_en/trap got %h/%h expected 0/0", dwrite_en, trap);
					errors++;
				end
			end
			reset_edges++;
		end
	end

	// every store against the expected queue, sampled mid-cycle
	always @(negedge clk)
	begin
		logic [15:0] ea;
		logic [15:0] ed;
		logic [1:0] een;
		logic [15:0] mask;
		if (!reset && dwrite_en != 2'b00)
		begin
			if (exp_addr.size() == 0)
			begin
				$display("unexpected store to address %h", dwrite_addr);
				errors++;
			end
			else
			begin
				ea = exp_addr.pop_front();
				ed = exp_data.pop_front();
				een = exp_en.pop_front();
				mask = {{8{een[1]}}, {8{een[0]}}};
				assert (dwrite_addr == ea)
				else
				begin
					$display("ERR dwrite_addr got %h expected %h", dwrite_addr, ea);
					errors++;
				end
				assert (dwrite_en == een)
				else
				begin
					$display("ERR dwrite_en got %h expected %h", dwrite_en, een);
					errors++;
				end
				assert ((dwrite_data & mask) == (ed & mask))
				else
				begin
					$display("ERR dwrite_data got %h expected %h", dwrite_data & mask, ed);
					errors++;
				end
			end
		end
	end

	// read address while a direct load sits in issue
	always @(negedge clk)
	begin
		logic [15:0] ra;
		if (!reset && is_direct_load(iread_data[7:0]))
		begin
			if (exp_raddr.size() == 0)
			begin
				$display("direct load issued that the program does not contain");
				errors++;
			end
			else
			begin
				ra = exp_raddr.pop_front();
				assert (dread_addr == ra)
				else
				begin
					$display("ERR dread_addr got %h expected %h", dread_addr, ra);
					errors++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		if (!reset)
			cycles++;
		if (cycles > limit)
		begin
			$display("timeout: trap not reached within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		build_program();
		limit = n_inst + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (!trap)
			@(negedge clk);
		if (exp_addr.size() != 0)
		begin
			$display("%0d expected stores never happened", exp_addr.size());
			errors++;
		end
		if (exp_raddr.size() != 0)
		begin
			$display("%0d expected direct loads were never issued", exp_raddr.size());
			errors++;
		end
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== acc_cpu.f ====
hdl/acc_isa_pkg.sv
hdl/acc_alu_pkg.sv
hdl/issue_stage.sv
hdl/exec_decode.sv
hdl/acc_alu.sv
hdl/regfile.sv
hdl/flag_unit.sv
hdl/acc_cpu.sv
tb/tb_memories.sv
tb/tb_acc_cpu.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_acc_cpu
FILELIST = acc_cpu.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
